// File: axi_slice_pkg.sv
`default_nettype none

package axi_slice_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and memory geometry
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = DATA_W / 8;
    localparam int ID_W      = 4;
    localparam int LEN_W     = 4;  // AXI3 bursts are at most 16 beats.
    localparam int MEM_WORDS = 256;
    localparam int IDX_W     = $clog2(MEM_WORDS);

    // First byte address that lies outside the memory.
    localparam logic [ADDR_W-1:0] MEM_LIMIT = ADDR_W'(MEM_WORDS * 4);

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    typedef enum logic [1:0] {
        slice_bypass,
        slice_forward,
        slice_reverse,
        slice_full
    } reg_slice_mode_t;

    localparam reg_slice_mode_t SLICE_MODE = slice_full;

    // Modes with a registered forward path also delay the peripheral reset.
    function automatic int reset_stages(input reg_slice_mode_t mode);
        case (mode)
            slice_bypass, slice_reverse : return 0;
            default                     : return 1;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Channel payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi3_aw_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi3_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi3_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_t           resp;
    } axi3_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_t             resp;
        logic              last;
    } axi3_r_t;

endpackage

`default_nettype wire

// File: axi_channel_slice.sv
`timescale 1ns/10ps
`default_nettype none

module axi_channel_slice #(
    parameter type payload_t = logic,
    parameter axi_slice_pkg::reg_slice_mode_t mode = axi_slice_pkg::slice_full
) (
    input  logic     aclk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    generate
        if (mode == axi_slice_pkg::slice_bypass) begin : g_bypass
            assign out_valid = in_valid;
            assign out_data  = in_data;
            assign in_ready  = out_ready;
        end else if (mode == axi_slice_pkg::slice_forward) begin : g_forward
            logic     valid_q;
            payload_t data_q;

            assign in_ready  = !valid_q || out_ready;  // Accept when empty or draining.
            assign out_valid = valid_q;
            assign out_data  = data_q;

            always_ff @(posedge aclk) begin
                if (rst) begin
                    valid_q <= 1'b0;
                end else if (in_ready) begin
                    valid_q <= in_valid;
                end
            end

            always_ff @(posedge aclk) begin
                if (in_valid && in_ready) begin
                    data_q <= in_data;
                end
            end
        end else if (mode == axi_slice_pkg::slice_reverse) begin : g_reverse
            logic     skid_valid;
            logic     ready_q;
            logic     load_skid;
            payload_t skid_data;

            // A payload is parked only when the output stalls on a new input.
            assign load_skid = !skid_valid && in_valid && ready_q && !out_ready;
            assign in_ready  = ready_q;
            assign out_valid = skid_valid || (in_valid && ready_q);
            assign out_data  = skid_valid ? skid_data : in_data;

            always_ff @(posedge aclk) begin
                if (rst) begin
                    skid_valid <= 1'b0;
                    ready_q    <= 1'b0;
                end else if (skid_valid) begin
                    if (out_ready) begin
                        skid_valid <= 1'b0;
                        ready_q    <= 1'b1;
                    end
                end else if (load_skid) begin
                    skid_valid <= 1'b1;
                    ready_q    <= 1'b0;
                end else begin
                    ready_q <= 1'b1;
                end
            end

            always_ff @(posedge aclk) begin
                if (load_skid) begin
                    skid_data <= in_data;
                end
            end
        end else begin : g_full
            logic     main_valid;
            logic     skid_valid;
            logic     ready_q;
            logic     in_fire;
            logic     load_skid;
            logic     load_main;
            payload_t main_data;
            payload_t skid_data;

            assign in_fire   = in_valid && ready_q;
            assign load_skid = in_fire && main_valid && !out_ready;  // Main slot is stuck.
            assign load_main = in_fire && !load_skid;
            assign in_ready  = ready_q;
            assign out_valid = main_valid;
            assign out_data  = main_data;

            always_ff @(posedge aclk) begin
                if (rst) begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                    ready_q    <= 1'b0;
                end else if (skid_valid) begin
                    if (out_ready) begin
                        skid_valid <= 1'b0;  // Skid moves into the main slot.
                        ready_q    <= 1'b1;
                    end
                end else if (load_skid) begin
                    skid_valid <= 1'b1;
                    ready_q    <= 1'b0;
                end else begin
                    ready_q <= 1'b1;
                    if (load_main) begin
                        main_valid <= 1'b1;
                    end else if (out_ready) begin
                        main_valid <= 1'b0;
                    end
                end
            end

            always_ff @(posedge aclk) begin
                if (skid_valid && out_ready) begin
                    main_data <= skid_data;
                end else if (load_main) begin
                    main_data <= in_data;
                end
                if (load_skid) begin
                    skid_data <= in_data;
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: axi3_reg_slice.sv
`timescale 1ns/10ps
`default_nettype none

module axi3_reg_slice (
    input  logic                    aclk,
    input  logic                    rst,
    input  axi_slice_pkg::axi3_aw_t s_aw,
    input  logic                    s_aw_valid,
    output logic                    s_aw_ready,
    input  axi_slice_pkg::axi3_w_t  s_w,
    input  logic                    s_w_valid,
    output logic                    s_w_ready,
    output axi_slice_pkg::axi3_b_t  s_b,
    output logic                    s_b_valid,
    input  logic                    s_b_ready,
    input  axi_slice_pkg::axi3_ar_t s_ar,
    input  logic                    s_ar_valid,
    output logic                    s_ar_ready,
    output axi_slice_pkg::axi3_r_t  s_r,
    output logic                    s_r_valid,
    input  logic                    s_r_ready,
    output axi_slice_pkg::axi3_aw_t m_aw,
    output logic                    m_aw_valid,
    input  logic                    m_aw_ready,
    output axi_slice_pkg::axi3_w_t  m_w,
    output logic                    m_w_valid,
    input  logic                    m_w_ready,
    input  axi_slice_pkg::axi3_b_t  m_b,
    input  logic                    m_b_valid,
    output logic                    m_b_ready,
    output axi_slice_pkg::axi3_ar_t m_ar,
    output logic                    m_ar_valid,
    input  logic                    m_ar_ready,
    input  axi_slice_pkg::axi3_r_t  m_r,
    input  logic                    m_r_valid,
    output logic                    m_r_ready,
    output logic                    mem_rst
);

    ////////////////////////////////////////////////////////////
    // Request channels, controller to peripheral
    ////////////////////////////////////////////////////////////

    axi_channel_slice #(
        .payload_t ( axi_slice_pkg::axi3_aw_t ),
        .mode      ( axi_slice_pkg::SLICE_MODE )
    ) u_aw_slice (
        .aclk      ( aclk ),
        .rst       ( rst ),
        .in_valid  ( s_aw_valid ),
        .in_ready  ( s_aw_ready ),
        .in_data   ( s_aw ),
        .out_valid ( m_aw_valid ),
        .out_ready ( m_aw_ready ),
        .out_data  ( m_aw )
    );

    axi_channel_slice #(
        .payload_t ( axi_slice_pkg::axi3_w_t ),
        .mode      ( axi_slice_pkg::SLICE_MODE )
    ) u_w_slice (
        .aclk      ( aclk ),
        .rst       ( rst ),
        .in_valid  ( s_w_valid ),
        .in_ready  ( s_w_ready ),
        .in_data   ( s_w ),
        .out_valid ( m_w_valid ),
        .out_ready ( m_w_ready ),
        .out_data  ( m_w )
    );

    axi_channel_slice #(
        .payload_t ( axi_slice_pkg::axi3_ar_t ),
        .mode      ( axi_slice_pkg::SLICE_MODE )
    ) u_ar_slice (
        .aclk      ( aclk ),
        .rst       ( rst ),
        .in_valid  ( s_ar_valid ),
        .in_ready  ( s_ar_ready ),
        .in_data   ( s_ar ),
        .out_valid ( m_ar_valid ),
        .out_ready ( m_ar_ready ),
        .out_data  ( m_ar )
    );

    ////////////////////////////////////////////////////////////
    // Response channels, peripheral to controller
    ////////////////////////////////////////////////////////////

    axi_channel_slice #(
        .payload_t ( axi_slice_pkg::axi3_b_t ),
        .mode      ( axi_slice_pkg::SLICE_MODE )
    ) u_b_slice (
        .aclk      ( aclk ),
        .rst       ( rst ),
        .in_valid  ( m_b_valid ),
        .in_ready  ( m_b_ready ),
        .in_data   ( m_b ),
        .out_valid ( s_b_valid ),
        .out_ready ( s_b_ready ),
        .out_data  ( s_b )
    );

    axi_channel_slice #(
        .payload_t ( axi_slice_pkg::axi3_r_t ),
        .mode      ( axi_slice_pkg::SLICE_MODE )
    ) u_r_slice (
        .aclk      ( aclk ),
        .rst       ( rst ),
        .in_valid  ( m_r_valid ),
        .in_ready  ( m_r_ready ),
        .in_data   ( m_r ),
        .out_valid ( s_r_valid ),
        .out_ready ( s_r_ready ),
        .out_data  ( s_r )
    );

    // The peripheral leaves reset in step with the slice registers.
    generate
        if (axi_slice_pkg::reset_stages(axi_slice_pkg::SLICE_MODE) == 0) begin : g_rst_direct
            assign mem_rst = rst;
        end else begin : g_rst_pipe
            localparam int STAGES = axi_slice_pkg::reset_stages(axi_slice_pkg::SLICE_MODE);

            logic [STAGES-1:0] rst_pipe;

            always_ff @(posedge aclk) begin
                rst_pipe[0] <= rst;
                for (int i = 1; i < STAGES; i++) begin
                    rst_pipe[i] <= rst_pipe[i-1];
                end
            end

            assign mem_rst = rst_pipe[STAGES-1];
        end
    endgenerate

endmodule

`default_nettype wire

// File: axi3_mem.sv
`timescale 1ns/10ps
`default_nettype none

module axi3_mem (
    input  logic                    aclk,
    input  logic                    rst,
    input  axi_slice_pkg::axi3_aw_t aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  axi_slice_pkg::axi3_w_t  w,
    input  logic                    w_valid,
    output logic                    w_ready,
    output axi_slice_pkg::axi3_b_t  b,
    output logic                    b_valid,
    input  logic                    b_ready,
    input  axi_slice_pkg::axi3_ar_t ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output axi_slice_pkg::axi3_r_t  r,
    output logic                    r_valid,
    input  logic                    r_ready
);

    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_t;

    typedef enum logic {
        rd_idle,
        rd_data
    } rd_state_t;

    wr_state_t                           wr_state;
    rd_state_t                           rd_state;
    logic [axi_slice_pkg::DATA_W-1:0]    mem [axi_slice_pkg::MEM_WORDS];
    logic [axi_slice_pkg::ID_W-1:0]      wr_id;
    logic [axi_slice_pkg::IDX_W-1:0]     wr_idx;
    logic                                wr_err;
    logic [axi_slice_pkg::ID_W-1:0]      rd_id;
    logic [axi_slice_pkg::IDX_W-1:0]     rd_idx;
    logic [axi_slice_pkg::LEN_W-1:0]     rd_cnt;
    logic                                rd_err;
    logic                                aw_fire;
    logic                                w_fire;
    logic                                ar_fire;
    logic                                r_fire;

    ////////////////////////////////////////////////////////////
    // Write engine
    ////////////////////////////////////////////////////////////

    assign aw_ready = (wr_state == wr_idle);
    assign w_ready  = (wr_state == wr_data);
    assign b_valid  = (wr_state == wr_resp);
    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;
    assign b.id     = wr_id;
    assign b.resp   = wr_err ? axi_slice_pkg::resp_slverr : axi_slice_pkg::resp_okay;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: if (aw_fire) wr_state <= wr_data;
                wr_data: if (w_fire && w.last) wr_state <= wr_resp;
                wr_resp: if (b_ready) wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_fire) begin
            wr_id  <= aw.id;
            wr_idx <= aw.addr[axi_slice_pkg::IDX_W+1:2];
            wr_err <= (aw.addr >= axi_slice_pkg::MEM_LIMIT);
        end else if (w_fire) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    // Byte lanes merge under the strobe; an errored burst leaves memory alone.
    always_ff @(posedge aclk) begin
        if (w_fire && !wr_err) begin
            for (int i = 0; i < axi_slice_pkg::STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read engine
    ////////////////////////////////////////////////////////////

    assign ar_ready = (rd_state == rd_idle);
    assign r_valid  = (rd_state == rd_data);
    assign ar_fire  = ar_valid && ar_ready;
    assign r_fire   = r_valid && r_ready;
    assign r.id     = rd_id;
    assign r.data   = rd_err ? '0 : mem[rd_idx];
    assign r.resp   = rd_err ? axi_slice_pkg::resp_slverr : axi_slice_pkg::resp_okay;
    assign r.last   = (rd_cnt == '0);  // Counter holds the beats still to come.

    always_ff @(posedge aclk) begin
        if (rst) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: if (ar_fire) rd_state <= rd_data;
                rd_data: if (r_fire && r.last) rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_fire) begin
            rd_id  <= ar.id;
            rd_idx <= ar.addr[axi_slice_pkg::IDX_W+1:2];
            rd_cnt <= ar.len;
            rd_err <= (ar.addr >= axi_slice_pkg::MEM_LIMIT);
        end else if (r_fire) begin
            rd_idx <= rd_idx + 1'b1;
            rd_cnt <= rd_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: axi3_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module axi3_mem_subsys (
    input  logic                    aclk,
    input  logic                    rst,
    input  axi_slice_pkg::axi3_aw_t s_aw,
    input  logic                    s_aw_valid,
    output logic                    s_aw_ready,
    input  axi_slice_pkg::axi3_w_t  s_w,
    input  logic                    s_w_valid,
    output logic                    s_w_ready,
    output axi_slice_pkg::axi3_b_t  s_b,
    output logic                    s_b_valid,
    input  logic                    s_b_ready,
    input  axi_slice_pkg::axi3_ar_t s_ar,
    input  logic                    s_ar_valid,
    output logic                    s_ar_ready,
    output axi_slice_pkg::axi3_r_t  s_r,
    output logic                    s_r_valid,
    input  logic                    s_r_ready
);

    axi_slice_pkg::axi3_aw_t m_aw;
    logic                    m_aw_valid;
    logic                    m_aw_ready;
    axi_slice_pkg::axi3_w_t  m_w;
    logic                    m_w_valid;
    logic                    m_w_ready;
    axi_slice_pkg::axi3_b_t  m_b;
    logic                    m_b_valid;
    logic                    m_b_ready;
    axi_slice_pkg::axi3_ar_t m_ar;
    logic                    m_ar_valid;
    logic                    m_ar_ready;
    axi_slice_pkg::axi3_r_t  m_r;
    logic                    m_r_valid;
    logic                    m_r_ready;
    logic                    mem_rst;

    axi3_reg_slice u_reg_slice (.*);  // Port names match the local nets one to one.

    axi3_mem u_mem (
        .aclk     ( aclk ),
        .rst      ( mem_rst ),
        .aw       ( m_aw ),
        .aw_valid ( m_aw_valid ),
        .aw_ready ( m_aw_ready ),
        .w        ( m_w ),
        .w_valid  ( m_w_valid ),
        .w_ready  ( m_w_ready ),
        .b        ( m_b ),
        .b_valid  ( m_b_valid ),
        .b_ready  ( m_b_ready ),
        .ar       ( m_ar ),
        .ar_valid ( m_ar_valid ),
        .ar_ready ( m_ar_ready ),
        .r        ( m_r ),
        .r_valid  ( m_r_valid ),
        .r_ready  ( m_r_ready )
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0) clk = ~clk;  // First rising edge comes half a period in.
    end

endmodule

`default_nettype wire

// File: tb_axi3_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi3_asserts #(
    parameter type payload_t = logic
) (
    input logic     aclk,
    input logic     rst,
    input logic     in_valid,
    input logic     in_ready,
    input payload_t in_data,
    input logic     out_valid,
    input logic     out_ready,
    input payload_t out_data
);

    int fail_count = 0;

    // A stalled source keeps valid up and the payload frozen.
    a_in_hold : assert property (@(posedge aclk) disable iff (rst)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_data)))
        else begin
            $error("slice input dropped valid or changed payload while stalled");
            fail_count++;
        end

    a_out_hold : assert property (@(posedge aclk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else begin
            $error("slice output dropped valid or changed payload while stalled");
            fail_count++;
        end

    // The first edge of reset still shows the old state.
    a_rst_idle : assert property (@(posedge aclk)
        (rst && $past(rst)) |-> !out_valid)
        else begin
            $error("slice output valid is high during reset");
            fail_count++;
        end

endmodule

bind axi_channel_slice tb_axi3_asserts #(
    .payload_t ( payload_t )
) u_asserts (
    .aclk      ( aclk ),
    .rst       ( rst ),
    .in_valid  ( in_valid ),
    .in_ready  ( in_ready ),
    .in_data   ( in_data ),
    .out_valid ( out_valid ),
    .out_ready ( out_ready ),
    .out_data  ( out_data )
);

`default_nettype wire

// File: tb_axi3_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi3_mem_subsys;

    localparam int N_TRANS        = 200;
    localparam int MAX_BEATS      = 16;
    localparam int TIMEOUT_CYCLES = N_TRANS * MAX_BEATS * 8 + 4000;  // Margin covers the fill.
    localparam int READY_PCT      = 70;
    localparam int GAP_PCT        = 30;

    logic                    aclk;
    logic                    rst;
    axi_slice_pkg::axi3_aw_t s_aw;
    logic                    s_aw_valid;
    logic                    s_aw_ready;
    axi_slice_pkg::axi3_w_t  s_w;
    logic                    s_w_valid;
    logic                    s_w_ready;
    axi_slice_pkg::axi3_b_t  s_b;
    logic                    s_b_valid;
    logic                    s_b_ready;
    axi_slice_pkg::axi3_ar_t s_ar;
    logic                    s_ar_valid;
    logic                    s_ar_ready;
    axi_slice_pkg::axi3_r_t  s_r;
    logic                    s_r_valid;
    logic                    s_r_ready;

    int                      seed;
    int                      errors;
    int                      n_trans;
    int                      total_beats;
    logic [31:0]             model_mem [256];
    logic [31:0]             wr_data [MAX_BEATS];
    logic [3:0]              wr_strb [MAX_BEATS];

    tb_clk_gen u_clk_gen (.clk(aclk));

    axi3_mem_subsys u_dut (.*);

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic bit chance(input int pct);
        return (($random(seed) & 32'h7fff_ffff) % 100) < pct;
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return {idx[7:0] ^ 8'h5a, ~idx[7:0], idx[7:0], 8'hc3};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] word;
        word = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return word;
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("ERR %s: expected %h, actual %h", test, exp, act);
    endtask

    task automatic check_idle(input string test);
        if (s_b_valid !== 1'b0) report_mismatch({test, "_bvalid"}, 32'd0, 32'(s_b_valid));
        if (s_r_valid !== 1'b0) report_mismatch({test, "_rvalid"}, 32'd0, 32'(s_r_valid));
    endtask

    task automatic wait_gap();
        while (chance(GAP_PCT)) begin
            @(negedge aclk);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Write and read transactions
    ////////////////////////////////////////////////////////////

    task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                               input logic [3:0] len);
        axi_slice_pkg::axi3_b_t b_seen;
        logic                   in_range;
        logic [7:0]             idx;
        logic                   got;
        in_range = (addr < 32'd1024);
        idx      = addr[9:2];
        got      = 1'b0;
        fork
            begin
                wait_gap();
                s_aw       = '{id: id, addr: addr, len: len, size: 3'd2, burst: 2'b01};
                s_aw_valid = 1'b1;
                do @(posedge aclk); while (!s_aw_ready);
                @(negedge aclk);
                s_aw_valid = 1'b0;
            end
            begin
                for (int i = 0; i <= len; i++) begin
                    while (chance(GAP_PCT)) begin
                        s_w_valid = 1'b0;
                        @(negedge aclk);
                    end
                    s_w       = '{id: id, data: wr_data[i], strb: wr_strb[i], last: (i == len)};
                    s_w_valid = 1'b1;
                    do @(posedge aclk); while (!s_w_ready);
                    @(negedge aclk);
                end
                s_w_valid = 1'b0;
            end
            begin
                while (!got) begin
                    s_b_ready = chance(READY_PCT);
                    @(posedge aclk);
                    if (s_b_valid && s_b_ready) begin
                        b_seen = s_b;
                        got    = 1'b1;
                    end
                    @(negedge aclk);
                end
                s_b_ready = 1'b0;
            end
        join
        if (b_seen.id !== id) report_mismatch("write_bid", 32'(id), 32'(b_seen.id));
        if (b_seen.resp !== (in_range ? axi_slice_pkg::resp_okay : axi_slice_pkg::resp_slverr))
            report_mismatch("write_bresp", in_range ? 32'h0 : 32'h2, 32'(b_seen.resp));
        if (in_range) begin
            for (int i = 0; i <= len; i++) begin
                model_mem[idx + i] = merge_bytes(model_mem[idx + i], wr_data[i], wr_strb[i]);
            end
        end
        n_trans++;
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                              input logic [3:0] len);
        logic [31:0] exp_data [MAX_BEATS];
        logic [1:0]  exp_resp;
        logic        in_range;
        logic [7:0]  idx;
        logic        got;
        int          beats;
        in_range = (addr < 32'd1024);
        idx      = addr[9:2];
        exp_resp = in_range ? axi_slice_pkg::resp_okay : axi_slice_pkg::resp_slverr;
        got      = 1'b0;
        beats    = 0;
        for (int i = 0; i <= len; i++) begin
            exp_data[i] = in_range ? model_mem[idx + i] : 32'd0;  // Errored reads return zero.
        end
        fork
            begin
                wait_gap();
                s_ar       = '{id: id, addr: addr, len: len, size: 3'd2, burst: 2'b01};
                s_ar_valid = 1'b1;
                do @(posedge aclk); while (!s_ar_ready);
                @(negedge aclk);
                s_ar_valid = 1'b0;
            end
            begin
                while (!got) begin
                    s_r_ready = chance(READY_PCT);
                    @(posedge aclk);
                    if (s_r_valid && s_r_ready) begin
                        if (s_r.data !== exp_data[beats])
                            report_mismatch("read_data", exp_data[beats], s_r.data);
                        if (s_r.resp !== exp_resp)
                            report_mismatch("read_resp", 32'(exp_resp), 32'(s_r.resp));
                        if (s_r.id !== id) report_mismatch("read_rid", 32'(id), 32'(s_r.id));
                        if (s_r.last !== (beats == len))
                            report_mismatch("read_last", 32'(beats == len), 32'(s_r.last));
                        got = s_r.last || (beats >= len);
                        beats++;
                        total_beats++;
                    end
                    @(negedge aclk);
                end
                s_r_ready = 1'b0;
            end
        join
        if (beats != len + 1) report_mismatch("read_beats", 32'(len + 1), 32'(beats));
        n_trans++;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic [3:0]  id;
        logic [3:0]  len;
        logic [31:0] addr;
        logic        out_of_range;
        int          word;
        int          assert_fails;
        seed        = 15597;
        errors      = 0;
        n_trans     = 0;
        total_beats = 0;
        rst         = 1'b1;
        s_aw        = '0;
        s_aw_valid  = 1'b0;
        s_w         = '0;
        s_w_valid   = 1'b0;
        s_b_ready   = 1'b0;
        s_ar        = '0;
        s_ar_valid  = 1'b0;
        s_r_ready   = 1'b0;

        for (int i = 0; i < 5; i++) begin
            @(posedge aclk);
            if (i > 0) check_idle("reset");  // Registers are unknown before the first edge.
        end
        @(negedge aclk);
        rst = 1'b0;
        repeat (4) begin
            @(posedge aclk);
            check_idle("after_reset");
        end
        @(negedge aclk);

        // Every word gets a known value so that later reads never see X.
        for (int blk = 0; blk < 16; blk++) begin
            for (int i = 0; i < MAX_BEATS; i++) begin
                wr_data[i] = fill_word(blk * 16 + i);
                wr_strb[i] = 4'hf;
            end
            write_burst(blk[3:0], 32'(blk * 64), 4'd15);
        end

        for (int t = 0; t < N_TRANS; t++) begin
            id           = $random(seed);
            len          = $random(seed);
            word         = ($random(seed) & 32'hff) % (256 - len);
            out_of_range = (($random(seed) & 7) == 0);
            addr         = {22'd0, word[7:0], 2'b00};
            if (out_of_range) begin
                addr = addr | (((($random(seed) & 32'h3f) + 1)) << 10);
            end
            if ($random(seed) & 1) begin
                for (int i = 0; i < MAX_BEATS; i++) begin
                    wr_data[i] = $random(seed);
                    wr_strb[i] = $random(seed);
                end
                write_burst(id, addr, len);
                if (out_of_range) begin
                    read_burst(id, addr & 32'h3fc, len);  // Same word lanes must be untouched.
                end
            end else begin
                read_burst(id, addr, len);
            end
        end

        assert_fails = u_dut.u_reg_slice.u_aw_slice.u_asserts.fail_count
                     + u_dut.u_reg_slice.u_w_slice.u_asserts.fail_count
                     + u_dut.u_reg_slice.u_b_slice.u_asserts.fail_count
                     + u_dut.u_reg_slice.u_ar_slice.u_asserts.fail_count
                     + u_dut.u_reg_slice.u_r_slice.u_asserts.fail_count;

        $display("Done: %0d transactions, %0d read beats, %0d errors, %0d assertion failures",
                 n_trans, total_beats, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
axi_slice_pkg.sv
axi_channel_slice.sv
axi3_reg_slice.sv
axi3_mem.sv
axi3_mem_subsys.sv
tb_clk_gen.sv
tb_axi3_asserts.sv
tb_axi3_mem_subsys.sv
